//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;
	typedef logic [3:0]  cond_code;

	localparam cond_code COND_AL = 4'he;
	localparam cond_code COND_NV = 4'hf; // Not valid on this core

	localparam reg_num R_PC = 4'd15;

	typedef enum logic [3:0] {
		DP_AND,
		DP_EOR,
		DP_SUB,
		DP_RSB,
		DP_ADD,
		DP_ADC,
		DP_SBC,
		DP_RSC,
		DP_TST,
		DP_TEQ,
		DP_CMP,
		DP_CMN,
		DP_ORR,
		DP_MOV,
		DP_BIC,
		DP_MVN
	} dp_opcode;

	typedef enum logic [1:0] {
		SHIFT_LSL,
		SHIFT_LSR,
		SHIFT_ASR,
		SHIFT_ROR
	} shift_type;

endpackage

`default_nettype wire

//--- common/uarch_pkg.sv
`default_nettype none

package uarch_pkg;

	import isa_pkg::*;

	typedef struct packed {
		logic execute;      // Data-processing class
		logic undefined;
		logic conditional;  // Condition other than AL
		logic writeback;    // Writes rd
		logic update_flags;
		logic restore_spsr;
		logic branch;
		logic ldst;
		logic mul;
		logic psr;
	} ctrl_decode;

	typedef struct packed {
		logic      is_imm;
		logic[7:0] imm;
		logic[3:0] rotate;      // Rotate right by twice this
		shift_type shift;
		logic      shift_by_reg;
		logic[4:0] shift_imm;
		reg_num    rm;
		reg_num    rs;
	} snd_decode;

	typedef struct packed {
		dp_opcode op;
		reg_num   rn;
		reg_num   rd;
		logic     uses_rn;
	} data_decode;

	typedef struct packed {
		logic       load;
		logic       byte_access;
		logic       pre_index;
		logic       increment;
		logic       writeback;  // Base register update
		reg_num     rn;
		reg_num     rd;
		logic[11:0] off_imm;
		logic       off_is_imm;
	} ldst_decode;

	typedef struct packed {
		logic   accumulate;
		reg_num rd;
		reg_num rn;
		reg_num rs;
		reg_num rm;
	} mul_decode;

	typedef struct packed {
		logic   saved;       // SPSR instead of CPSR
		logic   write;       // MSR
		logic   wr_flags;
		logic   wr_control;
		reg_num rd;
	} psr_decode;

	typedef struct packed {
		logic link;
		word  offset;  // Sign-extended byte offset
	} branch_decode;

	typedef struct packed {
		cond_code     cond;
		ctrl_decode   ctrl;
		snd_decode    snd;
		data_decode   data;
		ldst_decode   ldst;
		mul_decode    mul;
		psr_decode    psr;
		branch_decode branch;
	} insn_decode;

endpackage

`default_nettype wire

//--- core/decode/core_decode_mux.sv
`default_nettype none

module core_decode_mux
(
	input  isa_pkg::word          insn,
	input  logic                  data_writeback,
	input  logic                  data_update_flags,
	input  logic                  data_restore_spsr,
	input  logic                  data_is_imm,
	input  logic                  ldst_is_imm,
	input  logic                  psr_is_imm,
	input  logic                  psr_write,
	input  logic                  mul_update_flags,

	output uarch_pkg::ctrl_decode ctrl,
	output logic                  snd_is_imm
);

	import isa_pkg::*;

	logic nv, mul_space, misc_space;
	logic is_data, is_ldst, is_mul, is_psr, is_branch;

	assign nv = insn[31:28] == COND_NV;
	assign mul_space = insn[27:25] == 3'b000 && insn[7] && insn[4]; // Multiply and extension space
	assign misc_space = insn[27:26] == 2'b00 && insn[24:23] == 2'b10 && !insn[20]; // Compare, no S

	assign is_mul = !nv && insn[27:22] == 6'b000000 && insn[7:4] == 4'b1001;
	assign is_psr = !nv
	             && ((insn[27:23] == 5'b00010 && !insn[20] && insn[7:4] == 4'b0000)
	              || (insn[27:23] == 5'b00110 && insn[21:20] == 2'b10));
	assign is_data = !nv && insn[27:26] == 2'b00 && !mul_space && !misc_space;
	assign is_ldst = !nv && insn[27:26] == 2'b01 && !(insn[25] && insn[4]);
	assign is_branch = !nv && insn[27:25] == 3'b101;

	always_comb begin
		ctrl = '0;
		ctrl.conditional = insn[31:28] != COND_AL;
		ctrl.execute = is_data;
		ctrl.ldst = is_ldst;
		ctrl.mul = is_mul;
		ctrl.psr = is_psr;
		ctrl.branch = is_branch;
		ctrl.undefined = !(is_data || is_ldst || is_mul || is_psr || is_branch);
		snd_is_imm = 1'b0;

		if (is_data) begin
			ctrl.writeback = data_writeback;
			ctrl.update_flags = data_update_flags;
			ctrl.restore_spsr = data_restore_spsr;
			snd_is_imm = data_is_imm;
		end else if (is_ldst) begin
			ctrl.writeback = insn[20]; // Loads write rd
			snd_is_imm = ldst_is_imm;
		end else if (is_mul) begin
			ctrl.writeback = 1'b1;
			ctrl.update_flags = mul_update_flags;
		end else if (is_psr) begin
			ctrl.writeback = !psr_write; // MRS only
			snd_is_imm = psr_is_imm;
		end else if (is_branch)
			ctrl.writeback = insn[24]; // Link register
	end

endmodule

`default_nettype wire

//--- core/decode/core_decode_snd.sv
`default_nettype none

module core_decode_snd
(
	input  isa_pkg::word         insn,
	input  logic                 is_imm,

	output uarch_pkg::snd_decode decode,
	output logic                 undefined
);

	import isa_pkg::*;

	always_comb begin
		decode = '0;
		decode.is_imm = is_imm;

		if (is_imm) begin
			decode.imm = insn[7:0];
			decode.rotate = insn[11:8];
		end else begin
			decode.rm = insn[3:0];
			decode.shift = shift_type'(insn[6:5]);
			decode.shift_by_reg = insn[4];
			if (insn[4])
				decode.rs = insn[11:8];
			else
				decode.shift_imm = insn[11:7];
		end
	end

	// PC is not allowed in a register-specified shift
	assign undefined = decode.shift_by_reg && (decode.rs == R_PC || decode.rm == R_PC);

endmodule

`default_nettype wire

//--- core/decode/core_decode_data.sv
`default_nettype none

module core_decode_data
(
	input  isa_pkg::word          insn,

	output uarch_pkg::data_decode decode,
	output logic                  writeback,
	output logic                  update_flags,
	output logic                  restore_spsr,
	output logic                  is_imm
);

	import isa_pkg::*;

	logic compare;

	assign decode.op = dp_opcode'(insn[24:21]);
	assign decode.rn = insn[19:16];
	assign decode.rd = insn[15:12];
	assign decode.uses_rn = decode.op != DP_MOV && decode.op != DP_MVN;

	assign compare = insn[24:23] == 2'b10; // TST, TEQ, CMP, CMN

	assign writeback = !compare;
	assign update_flags = insn[20] || compare;
	assign restore_spsr = insn[20] && decode.rd == R_PC; // MOVS pc and friends
	assign is_imm = insn[25];

endmodule

`default_nettype wire

//--- core/decode/core_decode_ldst_single.sv
`default_nettype none

module core_decode_ldst_single
(
	input  isa_pkg::word          insn,

	output uarch_pkg::ldst_decode decode,
	output logic                  is_imm
);

	assign decode.load = insn[20];
	assign decode.byte_access = insn[22];
	assign decode.pre_index = insn[24];
	assign decode.increment = insn[23];
	assign decode.writeback = insn[21] || !insn[24]; // Post-index always updates base

	assign decode.rn = insn[19:16];
	assign decode.rd = insn[15:12];

	// Bit 25 set means a shifted register offset
	assign decode.off_is_imm = !insn[25];
	assign decode.off_imm = insn[25] ? 12'd0 : insn[11:0];

	assign is_imm = !insn[25];

endmodule

`default_nettype wire

//--- core/decode/core_decode_mul.sv
`default_nettype none

module core_decode_mul
(
	input  isa_pkg::word         insn,

	output uarch_pkg::mul_decode decode,
	output logic                 update_flags
);

	assign decode.accumulate = insn[21]; // MLA
	assign decode.rd = insn[19:16];      // Swapped against data processing
	assign decode.rn = insn[15:12];
	assign decode.rs = insn[11:8];
	assign decode.rm = insn[3:0];

	assign update_flags = insn[20];

endmodule

`default_nettype wire

//--- core/decode/core_decode_psr.sv
`default_nettype none

module core_decode_psr
(
	input  isa_pkg::word         insn,

	output uarch_pkg::psr_decode decode,
	output logic                 write,
	output logic                 is_imm
);

	assign write = insn[21]; // MSR
	assign is_imm = insn[25];

	assign decode.saved = insn[22];
	assign decode.write = write;

	// Field mask, only f and c exist here
	assign decode.wr_flags = write && insn[19];
	assign decode.wr_control = write && insn[16];

	assign decode.rd = write ? 4'd0 : insn[15:12];

endmodule

`default_nettype wire

//--- core/decode/core_decode.sv
`default_nettype none

module core_decode
(
	input  isa_pkg::word          insn,

	output uarch_pkg::insn_decode dec
);

	import uarch_pkg::*;

	ctrl_decode ctrl, dec_ctrl;
	snd_decode dec_snd;
	data_decode dec_data;
	ldst_decode dec_ldst;
	mul_decode dec_mul;
	psr_decode dec_psr;
	branch_decode dec_branch;

	logic data_writeback, data_update_flags, data_restore_spsr, data_is_imm;
	logic ldst_is_imm, psr_is_imm, psr_write, mul_update_flags;
	logic snd_is_imm, snd_undefined;

	assign dec.cond = insn[31:28];
	assign dec.ctrl = dec_ctrl;
	assign dec.snd = dec_snd;
	assign dec.data = dec_data;
	assign dec.ldst = dec_ldst;
	assign dec.mul = dec_mul;
	assign dec.psr = dec_psr;
	assign dec.branch = dec_branch;

	// ------------------------------------------------------------------------
	// Groups

	core_decode_mux mux
	(
		.*
	);

	core_decode_snd snd_operand
	(
		.decode(dec_snd),
		.is_imm(snd_is_imm),
		.undefined(snd_undefined),
		.*
	);

	core_decode_data group_data
	(
		.decode(dec_data),
		.writeback(data_writeback),
		.update_flags(data_update_flags),
		.restore_spsr(data_restore_spsr),
		.is_imm(data_is_imm),
		.*
	);

	core_decode_ldst_single group_ldst_single
	(
		.decode(dec_ldst),
		.is_imm(ldst_is_imm),
		.*
	);

	core_decode_mul group_mul
	(
		.decode(dec_mul),
		.update_flags(mul_update_flags),
		.*
	);

	core_decode_psr group_psr
	(
		.decode(dec_psr),
		.write(psr_write),
		.is_imm(psr_is_imm),
		.*
	);

	// ------------------------------------------------------------------------
	// Branch and final control

	assign dec_branch.link = insn[24];
	assign dec_branch.offset = {{6{insn[23]}}, insn[23:0], 2'b00}; // Words to bytes

	// A bad register shift turns a data instruction into an undefined one
	always_comb begin
		dec_ctrl = ctrl;
		if (ctrl.execute && snd_undefined) begin
			dec_ctrl.execute = 1'b0;
			dec_ctrl.undefined = 1'b1;
			dec_ctrl.writeback = 1'b0;
			dec_ctrl.update_flags = 1'b0;
			dec_ctrl.restore_spsr = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/core_decode_stage.sv
`default_nettype none

module core_decode_stage
(
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  in_valid,
	output logic                  in_ready,
	input  isa_pkg::word          insn,

	output logic                  out_valid,
	input  logic                  out_ready,
	output uarch_pkg::insn_decode dec
);

	import uarch_pkg::*;

	insn_decode next_dec;

	core_decode decoder
	(
		.insn(insn),
		.dec(next_dec)
	);

	// ------------------------------------------------------------------------
	// Pipeline register

	assign in_ready = !out_valid || out_ready; // Empty or draining

	always_ff @(posedge clk)
		if (reset)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;

	always_ff @(posedge clk)
		if (in_valid && in_ready)
			dec <= next_dec;

endmodule

`default_nettype wire

//--- testbench/decode_sva.sv
`default_nettype none

module decode_sva
(
	input logic                  clk,
	input logic                  reset,
	input logic                  in_valid,
	input logic                  in_ready,
	input logic                  out_valid,
	input logic                  out_ready,
	input uarch_pkg::insn_decode dec
);

	assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high after reset");

	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(dec))
		else $error("Output record changed while stalled");

	assert property (@(posedge clk) disable iff (reset)
		in_ready == (!out_valid || out_ready))
		else $error("in_ready does not follow the output side");

	// An accepted instruction shows up one cycle later
	assert property (@(posedge clk) disable iff (reset) in_valid && in_ready |=> out_valid)
		else $error("Accepted instruction did not reach the output");

endmodule

bind core_decode_stage decode_sva handshake_checks (.*);

`default_nettype wire

//--- testbench/tb_decode.sv
`default_nettype none

module tb_decode;

	import isa_pkg::*;
	import uarch_pkg::*;

	localparam int NUM_INSNS = 2000;
	localparam int TIMEOUT_CYCLES = 4 * NUM_INSNS;

	logic       clk = 1'b0;
	logic       reset;
	logic       in_valid;
	logic       in_ready;
	word        insn;
	logic       out_valid;
	logic       out_ready;
	insn_decode dec;

	logic [31:0] lfsr = 32'hd150;
	insn_decode  expected[$];
	word         expected_insn[$];
	word         cur_insn;
	logic        held;
	int          errors = 0;
	int          sent = 0;
	int          received = 0;
	int          cycles = 0;

	core_decode_stage UUT
	(
		.*
	);

	always #4 clk = !clk;

	// ------------------------------------------------------------------------
	// Stimulus

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return r;
	endfunction

	function automatic word make_insn();
		logic [2:0] kind;
		word        w;
		kind = rand_bits(3);
		w = rand_bits(32);
		case (kind)
			3'd0: w[27:25] = 3'b000; // Register operand, may hit multiply space
			3'd1: w[27:25] = 3'b001;
			3'd2: w[27:26] = 2'b01;
			3'd3: begin
				w[27:22] = 6'b000000;
				w[7:4] = 4'b1001;
			end
			3'd4: begin // MRS, or MSR from a register
				w[27:23] = 5'b00010;
				w[20] = 1'b0;
				w[7:4] = 4'b0000;
			end
			3'd5: begin
				w[27:23] = 5'b00110;
				w[21:20] = 2'b10;
			end
			3'd6: w[27:25] = 3'b101;
			default: ;
		endcase
		return w;
	endfunction

	// ------------------------------------------------------------------------
	// Reference decoder

	function automatic insn_decode model_decode(input word w);
		insn_decode m;
		logic       nv, is_data, is_ldst, is_mul, is_psr, is_branch;
		logic       compare, bad_shift;
		m = '0;
		m.cond = w[31:28];
		nv = w[31:28] == 4'hf;
		compare = w[24:23] == 2'b10;

		is_mul = !nv && w[27:22] == 6'b000000 && w[7:4] == 4'b1001;
		is_psr = !nv && ((w[27:23] == 5'b00010 && !w[20] && w[7:4] == 4'b0000)
			|| (w[27:23] == 5'b00110 && w[21:20] == 2'b10));
		// Compares without S and the multiply space are not data processing
		is_data = !nv && w[27:26] == 2'b00 && !(compare && !w[20])
			&& !(!w[25] && w[7] && w[4]);
		is_ldst = !nv && w[27:26] == 2'b01 && !(w[25] && w[4]);
		is_branch = !nv && w[27:25] == 3'b101;

		// Operand form
		m.snd.is_imm = is_data || is_psr ? w[25] : is_ldst ? !w[25] : 1'b0;
		if (m.snd.is_imm) begin
			m.snd.imm = w[7:0];
			m.snd.rotate = w[11:8];
		end else begin
			m.snd.rm = w[3:0];
			m.snd.shift = shift_type'(w[6:5]);
			m.snd.shift_by_reg = w[4];
			if (w[4])
				m.snd.rs = w[11:8];
			else
				m.snd.shift_imm = w[11:7];
		end
		bad_shift = m.snd.shift_by_reg && (w[11:8] == 4'd15 || w[3:0] == 4'd15);

		m.data.op = dp_opcode'(w[24:21]);
		m.data.rn = w[19:16];
		m.data.rd = w[15:12];
		m.data.uses_rn = !(w[24:21] == 4'd13 || w[24:21] == 4'd15);

		m.ldst = {w[20], w[22], w[24], w[23], w[21] || !w[24], w[19:16], w[15:12],
			w[25] ? 12'd0 : w[11:0], !w[25]};

		m.mul.accumulate = w[21];
		m.mul.rd = w[19:16];
		m.mul.rn = w[15:12];
		m.mul.rs = w[11:8];
		m.mul.rm = w[3:0];

		m.psr.saved = w[22];
		m.psr.write = w[21];
		m.psr.wr_flags = w[21] && w[19];
		m.psr.wr_control = w[21] && w[16];
		m.psr.rd = w[21] ? 4'd0 : w[15:12];

		m.branch.link = w[24];
		m.branch.offset = {{8{w[23]}}, w[23:0]} << 2;

		m.ctrl.conditional = w[31:28] != 4'he;
		m.ctrl.ldst = is_ldst;
		m.ctrl.mul = is_mul;
		m.ctrl.psr = is_psr;
		m.ctrl.branch = is_branch;
		m.ctrl.execute = is_data && !bad_shift;
		m.ctrl.undefined = !(is_data && !bad_shift) && !is_ldst && !is_mul && !is_psr
			&& !is_branch;
		if (is_data && !bad_shift) begin
			m.ctrl.writeback = !compare;
			m.ctrl.update_flags = w[20] || compare;
			m.ctrl.restore_spsr = w[20] && w[15:12] == 4'd15;
		end else if (is_ldst)
			m.ctrl.writeback = w[20];
		else if (is_mul) begin
			m.ctrl.writeback = 1'b1;
			m.ctrl.update_flags = w[20];
		end else if (is_psr)
			m.ctrl.writeback = !w[21];
		else if (is_branch)
			m.ctrl.writeback = w[24];
		return m;
	endfunction

	// ------------------------------------------------------------------------
	// Checks

	task automatic compare_field(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got %h expected %h (insn %h)", name, got, exp, cur_insn);
		end
	endtask

	task automatic compare_decode(input insn_decode got, input insn_decode exp);
		compare_field("cond", got.cond, exp.cond);
		compare_field("ctrl", got.ctrl, exp.ctrl);
		compare_field("snd", got.snd, exp.snd);
		compare_field("data", got.data, exp.data);
		compare_field("ldst", got.ldst, exp.ldst);
		compare_field("mul", got.mul, exp.mul);
		compare_field("psr", got.psr, exp.psr);
		compare_field("branch", got.branch, exp.branch);
		compare_field("class_onehot", $countones({got.ctrl.execute, got.ctrl.undefined,
			got.ctrl.ldst, got.ctrl.mul, got.ctrl.psr, got.ctrl.branch}), 1);
	endtask

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		insn = '0;
		out_ready = 1'b0;
		cur_insn = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		compare_field("out_valid", out_valid, 1'b0);

		while ((sent < NUM_INSNS || expected.size() != 0) && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
			held = in_valid && !in_ready;
			if (in_valid && in_ready) begin
				expected.push_back(model_decode(insn));
				expected_insn.push_back(insn);
				sent++;
			end
			if (out_valid && out_ready) begin
				if (expected.size() == 0) begin
					errors++;
					$display("Output transfer with no instruction outstanding");
				end else begin
					cur_insn = expected_insn.pop_front();
					compare_decode(dec, expected.pop_front());
					received++;
				end
			end
			#1;
			if (!held) begin
				in_valid = sent < NUM_INSNS ? rand_bits(1) : 1'b0;
				insn = make_insn();
			end
			out_ready = rand_bits(1);
		end

		if (sent < NUM_INSNS || expected.size() != 0) begin
			errors++;
			$display("Timeout after %0d cycles, %0d sent and %0d decoded, %0d outstanding",
				cycles, sent, received, expected.size());
		end
		$display("%0d instructions decoded, %0d errors", received, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
common/isa_pkg.sv
common/uarch_pkg.sv
core/decode/core_decode_mux.sv
core/decode/core_decode_snd.sv
core/decode/core_decode_data.sv
core/decode/core_decode_ldst_single.sv
core/decode/core_decode_mul.sv
core/decode/core_decode_psr.sv
core/decode/core_decode.sv
hw/core_decode_stage.sv
testbench/decode_sva.sv
testbench/tb_decode.sv
